/* card_ctrl.f */
card_ctrl_pkg.sv
host_regs.sv
uart_port.sv
eeprom_emu.sv
card_ctrl_top.sv
card_ctrl_tb.sv

/* card_ctrl_patterns.txt */
# W addr data resp | R addr data resp | X byte | T byte | I level
# E opcode addr word (opcode 2 is READ) | all fields hex
R 08 00000000 0
W 08 00000003 0
R 08 00000003 0
W 08 00000000 0
W 44 0000BEEF 0
W 58 00001234 0
R 44 0000BEEF 0
R 58 00001234 0
W 20 DEADBEEF 2
R 20 00000000 2
W 00 000000A5 0
R 04 00000001 0
T A5
R 04 00000000 0
W 08 00000001 0
X 3C
I 1
R 04 00000002 0
R 00 0000003C 0
W 0C 00000001 0
I 0
X 11
X 22
R 04 00000006 0
R 00 00000022 0
W 0C 00000001 0
R 0C 00000000 0
E 2 01 0000BEEF
E 2 26 00001234
R 10 00000002 0
R 0C 00000002 0
I 0
W 08 00000002 0
I 1
E 1 06 00000000
R 10 00000002 0
W 0C 00000002 0
I 0

/* card_ctrl_pkg.sv */
package card_ctrl_pkg;

//////////////////////////////
// Register map

localparam int AXIL_ADDR_W = 7;

localparam logic [AXIL_ADDR_W-1:0] REG_UART_DATA   = 7'h00;
localparam logic [AXIL_ADDR_W-1:0] REG_UART_STATUS = 7'h04;
localparam logic [AXIL_ADDR_W-1:0] REG_IRQ_ENABLE  = 7'h08;
localparam logic [AXIL_ADDR_W-1:0] REG_IRQ_STATUS  = 7'h0C;
localparam logic [AXIL_ADDR_W-1:0] REG_EE_COUNT    = 7'h10;
// Config words 0..15 at 0x40..0x7C
localparam logic [AXIL_ADDR_W-1:0] REG_CFG_BASE    = 7'h40;

//////////////////////////////
// Function sizes

localparam int UART_DIV = 8;
localparam int UART_CNT_W = $clog2(UART_DIV);
localparam int CFG_WORDS = 16;
localparam int CFG_IDX_W = 4;
localparam int CFG_DATA_W = 16;
// Address bits sent by the Microwire master
localparam int EE_ADDR_BITS = 6;
localparam int EE_CNT_W = 4;

//////////////////////////////
// Encodings

typedef enum logic [1:0] {
	RESP_OKAY   = 2'b00,
	RESP_SLVERR = 2'b10
} axil_resp_e;

typedef enum logic [1:0] {
	MW_EXT   = 2'b00,
	MW_WRITE = 2'b01,
	MW_READ  = 2'b10,
	MW_ERASE = 2'b11
} mw_op_e;

typedef enum logic [2:0] {
	EE_IDLE,
	EE_START,
	EE_OPCODE,
	EE_ADDR,
	EE_DATA,
	EE_IGNORE
} ee_state_e;

// Shared by transmit and receive machines
typedef enum logic [1:0] {
	UART_IDLE,
	UART_START,
	UART_BITS,
	UART_STOP
} uart_state_e;

//////////////////////////////
// Bundles

typedef struct packed {
	logic [AXIL_ADDR_W-1:0] awaddr;
	logic                   awvalid;
	logic [31:0]            wdata;
	logic [3:0]             wstrb;
	logic                   wvalid;
	logic                   bready;
	logic [AXIL_ADDR_W-1:0] araddr;
	logic                   arvalid;
	logic                   rready;
} axil_req_s;

typedef struct packed {
	logic        awready;
	logic        wready;
	axil_resp_e  bresp;
	logic        bvalid;
	logic        arready;
	logic [31:0] rdata;
	axil_resp_e  rresp;
	logic        rvalid;
} axil_rsp_s;

typedef struct packed {
	logic       tx_start;
	logic [7:0] tx_byte;
	logic       rx_ack;
} uart_ctl_s;

typedef struct packed {
	logic       tx_busy;
	logic       rx_valid;
	logic       rx_overrun;
	logic [7:0] rx_byte;
	logic       rx_event;
} uart_stat_s;

typedef struct packed {
	logic                  wr_en;
	logic [CFG_IDX_W-1:0]  index;
	logic [CFG_DATA_W-1:0] word;
} cfg_wr_s;

endpackage

/* card_ctrl_tb.sv */
`timescale 1ns/1ps

module card_ctrl_tb import card_ctrl_pkg::*; ();

localparam int CLK_PERIOD = 40;
localparam int TIMEOUT = 200;
localparam int SK_HALF = 5;
localparam logic [31:0] SEED = 32'h861a;

logic clk_i = 1'b0;
logic reset_i;
axil_req_s axil_req;
axil_rsp_s axil_rsp;
logic irq_o;
logic uart_rx_i;
logic uart_tx_o;
logic ee_sk_i;
logic ee_cs_i;
logic ee_di_i;
logic ee_do_o;

// Bytes seen on uart_tx_o, oldest first
logic [7:0] tx_bytes [$];

card_ctrl_top UUT (
	.clk_i(clk_i),
	.reset_i(reset_i),
	.axil_req_i(axil_req),
	.axil_rsp_o(axil_rsp),
	.irq_o(irq_o),
	.uart_rx_i(uart_rx_i),
	.uart_tx_o(uart_tx_o),
	.ee_sk_i(ee_sk_i),
	.ee_cs_i(ee_cs_i),
	.ee_di_i(ee_di_i),
	.ee_do_o(ee_do_o)
);

always #(CLK_PERIOD/2) clk_i = ~clk_i;

//////////////////////////////
// Reporting

task automatic abort_run(input string why);
	$display("%s", why);
	$display("TEST FAIL");
	$fatal(1, "simulation stopped");
endtask

task automatic compare_value(input string name, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp)
		abort_run($sformatf("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp));
endtask

task automatic idle_gap();
	repeat ($urandom % 4) @(posedge clk_i);
endtask

//////////////////////////////
// AXI4-Lite master

task automatic axi_write(input logic [6:0] addr, input logic [31:0] data, input logic [1:0] resp);
	int cnt;
	@(posedge clk_i);
	axil_req.awaddr <= addr;
	axil_req.awvalid <= 1'b1;
	axil_req.wdata <= data;
	axil_req.wstrb <= 4'hf;
	axil_req.wvalid <= 1'b1;
	cnt = 0;
	@(negedge clk_i);
	while (!axil_rsp.awready && cnt < TIMEOUT) begin
		@(negedge clk_i);
		cnt++;
	end
	if (cnt >= TIMEOUT)
		abort_run("Timeout waiting for the write address handshake");
	compare_value("wready", axil_rsp.wready, 1);
	@(posedge clk_i);
	axil_req.awvalid <= 1'b0;
	axil_req.wvalid <= 1'b0;
	// Response one cycle after ready, then held under back-pressure
	@(negedge clk_i);
	compare_value("bvalid", axil_rsp.bvalid, 1);
	repeat ($urandom % 3) @(posedge clk_i);
	@(negedge clk_i);
	compare_value("bvalid", axil_rsp.bvalid, 1);
	compare_value("bresp", axil_rsp.bresp, resp);
	@(posedge clk_i);
	axil_req.bready <= 1'b1;
	@(posedge clk_i);
	axil_req.bready <= 1'b0;
	@(negedge clk_i);
	compare_value("bvalid", axil_rsp.bvalid, 0);
endtask

task automatic axi_read(input logic [6:0] addr, input logic [31:0] data, input logic [1:0] resp);
	int cnt;
	@(posedge clk_i);
	axil_req.araddr <= addr;
	axil_req.arvalid <= 1'b1;
	cnt = 0;
	@(negedge clk_i);
	while (!axil_rsp.arready && cnt < TIMEOUT) begin
		@(negedge clk_i);
		cnt++;
	end
	if (cnt >= TIMEOUT)
		abort_run("Timeout waiting for the read address handshake");
	@(posedge clk_i);
	axil_req.arvalid <= 1'b0;
	@(negedge clk_i);
	compare_value("rvalid", axil_rsp.rvalid, 1);
	compare_value("rdata", axil_rsp.rdata, data);
	compare_value("rresp", axil_rsp.rresp, resp);
	repeat ($urandom % 3) @(posedge clk_i);
	@(negedge clk_i);
	compare_value("rvalid", axil_rsp.rvalid, 1);
	compare_value("rdata", axil_rsp.rdata, data);
	@(posedge clk_i);
	axil_req.rready <= 1'b1;
	@(posedge clk_i);
	axil_req.rready <= 1'b0;
	@(negedge clk_i);
	compare_value("rvalid", axil_rsp.rvalid, 0);
endtask

//////////////////////////////
// Serial pins

task automatic uart_send(input logic [7:0] data);
	logic [9:0] frame;
	frame = {1'b1, data, 1'b0};
	for (int i = 0; i < 10; i++) begin
		@(posedge clk_i);
		uart_rx_i <= frame[i];
		repeat (UART_DIV-1) @(posedge clk_i);
	end
	// Idle gap so the receiver is back in idle
	repeat (UART_DIV) @(posedge clk_i);
endtask

task automatic uart_expect(input logic [7:0] data);
	int cnt;
	cnt = 0;
	while (tx_bytes.size() == 0 && cnt < TIMEOUT) begin
		@(negedge clk_i);
		cnt++;
	end
	if (cnt >= TIMEOUT)
		abort_run("Timeout waiting for a byte on uart_tx_o");
	compare_value("uart_tx_o byte", tx_bytes.pop_front(), data);
endtask

task automatic irq_expect(input logic level);
	@(negedge clk_i);
	compare_value("irq_o", irq_o, level);
endtask

// One SK period, do_o sampled just before the rising edge
task automatic clock_sk(input logic di, output logic dout);
	@(posedge clk_i);
	ee_di_i <= di;
	repeat (SK_HALF-1) @(posedge clk_i);
	@(negedge clk_i);
	dout = ee_do_o;
	@(posedge clk_i);
	ee_sk_i <= 1'b1;
	repeat (SK_HALF) @(posedge clk_i);
	ee_sk_i <= 1'b0;
endtask

task automatic microwire_read(input logic [1:0] op, input logic [5:0] addr,
		input logic [15:0] exp);
	logic [8:0] cmd;
	logic [15:0] word;
	logic dout;
	cmd = {1'b1, op, addr};
	word = '0;
	@(posedge clk_i);
	ee_cs_i <= 1'b1;
	// Start, opcode, address, then dummy bit and 16 data bits
	for (int i = 0; i < 26; i++) begin
		clock_sk((i < 9) ? cmd[8-i] : 1'b0, dout);
		if (i == 9)
			compare_value("ee_do_o dummy", dout, 0);
		else if (i > 9)
			word = {word[14:0], dout};
	end
	compare_value("ee_do_o word", word, exp);
	@(posedge clk_i);
	ee_cs_i <= 1'b0;
	ee_di_i <= 1'b0;
	repeat (4) @(posedge clk_i);
	@(negedge clk_i);
	compare_value("ee_do_o idle", ee_do_o, 0);
endtask

//////////////////////////////
// Transmit line monitor

initial begin : tx_monitor
	logic prev;
	logic [7:0] data;
	prev = 1'b1;
	forever begin
		@(negedge clk_i);
		if (prev === 1'b1 && uart_tx_o === 1'b0 && !reset_i) begin
			repeat (UART_DIV/2 - 1) @(negedge clk_i);
			compare_value("uart_tx_o start", uart_tx_o, 0);
			for (int i = 0; i < 8; i++) begin
				repeat (UART_DIV) @(negedge clk_i);
				data[i] = uart_tx_o;
			end
			repeat (UART_DIV) @(negedge clk_i);
			compare_value("uart_tx_o stop", uart_tx_o, 1);
			// Hand over once the stop bit has ended
			repeat (UART_DIV/2 + 1) @(negedge clk_i);
			tx_bytes.push_back(data);
		end
		prev = uart_tx_o;
	end
end

//////////////////////////////
// Pattern sequencer

initial begin
	int fd;
	int n;
	string op;
	string line;
	logic [31:0] f1;
	logic [31:0] f2;
	logic [31:0] f3;
	void'($urandom(SEED));
	reset_i <= 1'b1;
	axil_req <= '0;
	uart_rx_i <= 1'b1;
	ee_sk_i <= 1'b0;
	ee_cs_i <= 1'b0;
	ee_di_i <= 1'b0;
	repeat (10) @(posedge clk_i);
	reset_i <= 1'b0;
	fd = $fopen("card_ctrl_patterns.txt", "r");
	if (fd == 0)
		abort_run("Could not open the pattern file card_ctrl_patterns.txt");
	while (!$feof(fd)) begin
		n = $fscanf(fd, "%s", op);
		if (n == 1) begin
			if (op.substr(0, 0) == "#") begin
				n = $fgets(line, fd);
			end else begin
				idle_gap();
				case (op)
				"W": begin
					n = $fscanf(fd, "%h %h %h", f1, f2, f3);
					axi_write(f1[6:0], f2, f3[1:0]);
				end
				"R": begin
					n = $fscanf(fd, "%h %h %h", f1, f2, f3);
					axi_read(f1[6:0], f2, f3[1:0]);
				end
				"X": begin
					n = $fscanf(fd, "%h", f1);
					uart_send(f1[7:0]);
				end
				"T": begin
					n = $fscanf(fd, "%h", f1);
					uart_expect(f1[7:0]);
				end
				"E": begin
					n = $fscanf(fd, "%h %h %h", f1, f2, f3);
					microwire_read(f1[1:0], f2[5:0], f3[15:0]);
				end
				"I": begin
					n = $fscanf(fd, "%h", f1);
					irq_expect(f1[0]);
				end
				default: abort_run({"Unknown operation in the pattern file: ", op});
				endcase
			end
		end
	end
	$fclose(fd);
	// Every byte sent on uart_tx_o must have been expected
	compare_value("uart_tx_o extra bytes", tx_bytes.size(), 0);
	$display("TEST PASS");
	$finish;
end

endmodule

/* card_ctrl_top.sv */
`timescale 1ns/1ps

module card_ctrl_top import card_ctrl_pkg::*; (
	input  logic      clk_i,
	input  logic      reset_i,
	input  axil_req_s axil_req_i,
	output axil_rsp_s axil_rsp_o,
	output logic      irq_o,
	// Serial port
	input  logic      uart_rx_i,
	output logic      uart_tx_o,
	// Configuration EEPROM
	input  logic      ee_sk_i,
	input  logic      ee_cs_i,
	input  logic      ee_di_i,
	output logic      ee_do_o
);

uart_ctl_s uart_ctl;
uart_stat_s uart_stat;
cfg_wr_s cfg_wr;
logic [CFG_IDX_W-1:0] cfg_raddr;
logic [CFG_DATA_W-1:0] cfg_rdata;
logic ee_read_done;

host_regs host_regs_i(
	.clk_i(clk_i),
	.reset_i(reset_i),
	.axil_req_i(axil_req_i),
	.uart_stat_i(uart_stat),
	.cfg_rdata_i(cfg_rdata),
	.ee_read_done_i(ee_read_done),
	.axil_rsp_o(axil_rsp_o),
	.uart_ctl_o(uart_ctl),
	.cfg_wr_o(cfg_wr),
	.cfg_raddr_o(cfg_raddr),
	.irq_o(irq_o)
);

uart_port uart_port_i(
	.clk_i(clk_i),
	.reset_i(reset_i),
	.uart_ctl_i(uart_ctl),
	.uart_rx_i(uart_rx_i),
	.uart_stat_o(uart_stat),
	.uart_tx_o(uart_tx_o)
);

eeprom_emu eeprom_emu_i(
	.clk_i(clk_i),
	.reset_i(reset_i),
	.sk_i(ee_sk_i),
	.cs_i(ee_cs_i),
	.di_i(ee_di_i),
	.cfg_wr_i(cfg_wr),
	.cfg_raddr_i(cfg_raddr),
	.do_o(ee_do_o),
	.read_done_o(ee_read_done),
	.cfg_rdata_o(cfg_rdata)
);

endmodule

/* eeprom_emu.sv */
`timescale 1ns/1ps

module eeprom_emu import card_ctrl_pkg::*; (
	input  logic                  clk_i,
	input  logic                  reset_i,
	input  logic                  sk_i,
	input  logic                  cs_i,
	input  logic                  di_i,
	input  cfg_wr_s               cfg_wr_i,
	input  logic [CFG_IDX_W-1:0]  cfg_raddr_i,
	output logic                  do_o,
	output logic                  read_done_o,
	output logic [CFG_DATA_W-1:0] cfg_rdata_o
);

// Configuration store, host written
logic [CFG_DATA_W-1:0] mem [CFG_WORDS];

logic [1:0] sk_sync_q;
logic [1:0] cs_sync_q;
logic [1:0] di_sync_q;
logic sk_prev_q;
logic sk_s;
logic cs_s;
logic di_s;
logic sk_rise;

ee_state_e state_q;
mw_op_e op_q;
logic [EE_CNT_W-1:0] bit_cnt_q;
// Only the low address bits matter, so upper ones fall off the end
logic [CFG_IDX_W-2:0] addr_sh_q;
logic [CFG_DATA_W-1:0] data_sh_q;
logic do_q;
logic read_done_q;

always_ff @(posedge clk_i) begin
	if (cfg_wr_i.wr_en)
		mem[cfg_wr_i.index] <= cfg_wr_i.word;
end

assign cfg_rdata_o = mem[cfg_raddr_i];

//////////////////////////////
// Pin synchronizers

always_ff @(posedge clk_i) begin
	if (reset_i) begin
		sk_sync_q <= '0;
		cs_sync_q <= '0;
		di_sync_q <= '0;
		sk_prev_q <= 1'b0;
	end else begin
		sk_sync_q <= {sk_sync_q[0], sk_i};
		cs_sync_q <= {cs_sync_q[0], cs_i};
		di_sync_q <= {di_sync_q[0], di_i};
		sk_prev_q <= sk_s;
	end
end

assign sk_s = sk_sync_q[1];
assign cs_s = cs_sync_q[1];
assign di_s = di_sync_q[1];
assign sk_rise = sk_s && !sk_prev_q;

//////////////////////////////
// Command decoder

always_ff @(posedge clk_i) begin
	if (reset_i) begin
		state_q <= EE_IDLE;
		bit_cnt_q <= '0;
		do_q <= 1'b0;
		read_done_q <= 1'b0;
	end else begin
		read_done_q <= 1'b0;
		if (!cs_s) begin
			state_q <= EE_IDLE;
			do_q <= 1'b0;
		end else begin
			case (state_q)
			EE_IDLE: state_q <= EE_START;
			// Leading zeros before the start bit are skipped
			EE_START: if (sk_rise && di_s) begin
				bit_cnt_q <= '0;
				state_q <= EE_OPCODE;
			end
			EE_OPCODE: if (sk_rise) begin
				op_q <= mw_op_e'({op_q[0], di_s});
				bit_cnt_q <= bit_cnt_q + 1'b1;
				if (bit_cnt_q == EE_CNT_W'(1)) begin
					bit_cnt_q <= '0;
					state_q <= EE_ADDR;
				end
			end
			EE_ADDR: if (sk_rise) begin
				addr_sh_q <= {addr_sh_q[CFG_IDX_W-3:0], di_s};
				bit_cnt_q <= bit_cnt_q + 1'b1;
				if (bit_cnt_q == EE_CNT_W'(EE_ADDR_BITS-1)) begin
					// Dummy zero goes out first
					do_q <= 1'b0;
					bit_cnt_q <= '0;
					data_sh_q <= mem[{addr_sh_q, di_s}];
					state_q <= (op_q == MW_READ) ? EE_DATA : EE_IGNORE;
				end
			end
			EE_DATA: if (sk_rise) begin
				do_q <= data_sh_q[CFG_DATA_W-1];
				data_sh_q <= {data_sh_q[CFG_DATA_W-2:0], 1'b0};
				bit_cnt_q <= bit_cnt_q + 1'b1;
				if (bit_cnt_q == EE_CNT_W'(CFG_DATA_W-1)) begin
					read_done_q <= 1'b1;
					state_q <= EE_IGNORE;
				end
			end
			// no sequential reads, rest of the frame is dead
			EE_IGNORE: if (sk_rise)
				do_q <= 1'b0;
			default: state_q <= EE_IDLE;
			endcase
		end
	end
end

assign do_o = do_q;
assign read_done_o = read_done_q;

a_do_low_no_cs: assert property (@(posedge clk_i) disable iff (reset_i)
	!cs_s |=> !do_o);

endmodule

/* host_regs.sv */
`timescale 1ns/1ps

module host_regs import card_ctrl_pkg::*; (
	input  logic                  clk_i,
	input  logic                  reset_i,
	input  axil_req_s             axil_req_i,
	input  uart_stat_s            uart_stat_i,
	input  logic [CFG_DATA_W-1:0] cfg_rdata_i,
	input  logic                  ee_read_done_i,
	output axil_rsp_s             axil_rsp_o,
	output uart_ctl_s             uart_ctl_o,
	output cfg_wr_s               cfg_wr_o,
	output logic [CFG_IDX_W-1:0]  cfg_raddr_o,
	output logic                  irq_o
);

// AXI handshake state
logic wr_rdy_q;
logic rd_rdy_q;
logic bvalid_q;
logic rvalid_q;
axil_resp_e bresp_q;
axil_resp_e rresp_q;
logic [31:0] rdata_q;

// Register contents
logic [1:0] irq_en_q;
logic [1:0] irq_stat_q;
logic [7:0] ee_count_q;

// Commands to the functions
logic tx_start_q;
logic rx_ack_q;
logic [7:0] tx_byte_q;
logic cfg_wr_en_q;
logic [CFG_IDX_W-1:0] cfg_index_q;
logic [CFG_DATA_W-1:0] cfg_word_q;

// Decode
logic [AXIL_ADDR_W-1:0] wr_addr;
logic [AXIL_ADDR_W-1:0] rd_addr;
logic wr_cfg;
logic wr_hit;
logic rd_hit;
logic [31:0] rd_word;
logic [1:0] irq_set;
logic [1:0] irq_clr;

function automatic logic is_cfg(input logic [AXIL_ADDR_W-1:0] addr);
	is_cfg = addr[AXIL_ADDR_W-1] && (addr[1:0] == 2'b00);
endfunction

assign wr_addr = axil_req_i.awaddr;
assign rd_addr = axil_req_i.araddr;
assign wr_cfg = is_cfg(wr_addr);
assign wr_hit = wr_cfg || (wr_addr inside {REG_UART_DATA, REG_UART_STATUS,
	REG_IRQ_ENABLE, REG_IRQ_STATUS, REG_EE_COUNT});

// Store read goes out combinationally, comes back registered into rdata
assign cfg_raddr_o = rd_addr[CFG_IDX_W+1:2];

always_comb begin
	rd_hit = 1'b1;
	rd_word = '0;
	if (is_cfg(rd_addr)) begin
		rd_word = {16'b0, cfg_rdata_i};
	end else begin
		case (rd_addr)
		REG_UART_DATA:   rd_word = {24'b0, uart_stat_i.rx_byte};
		REG_UART_STATUS: rd_word = {29'b0, uart_stat_i.rx_overrun,
			uart_stat_i.rx_valid, uart_stat_i.tx_busy};
		REG_IRQ_ENABLE:  rd_word = {30'b0, irq_en_q};
		REG_IRQ_STATUS:  rd_word = {30'b0, irq_stat_q};
		REG_EE_COUNT:    rd_word = {24'b0, ee_count_q};
		default:         rd_hit = 1'b0;
		endcase
	end
end

//////////////////////////////
// AXI4-Lite responders

always_ff @(posedge clk_i) begin
	if (reset_i) begin
		wr_rdy_q <= 1'b0;
		rd_rdy_q <= 1'b0;
		bvalid_q <= 1'b0;
		rvalid_q <= 1'b0;
	end else begin
		// Ready pulses once per transaction, never while a response waits
		wr_rdy_q <= axil_req_i.awvalid && axil_req_i.wvalid && !bvalid_q && !wr_rdy_q;
		rd_rdy_q <= axil_req_i.arvalid && !rvalid_q && !rd_rdy_q;
		if (wr_rdy_q)
			bvalid_q <= 1'b1;
		else if (axil_req_i.bready)
			bvalid_q <= 1'b0;
		if (rd_rdy_q)
			rvalid_q <= 1'b1;
		else if (axil_req_i.rready)
			rvalid_q <= 1'b0;
	end
end

always_ff @(posedge clk_i) begin
	if (wr_rdy_q) begin
		bresp_q <= wr_hit ? RESP_OKAY : RESP_SLVERR;
		tx_byte_q <= axil_req_i.wdata[7:0];
		cfg_index_q <= wr_addr[CFG_IDX_W+1:2];
		cfg_word_q <= axil_req_i.wdata[CFG_DATA_W-1:0];
	end
	if (rd_rdy_q) begin
		rresp_q <= rd_hit ? RESP_OKAY : RESP_SLVERR;
		rdata_q <= rd_word;
	end
end

//////////////////////////////
// Commands, interrupts, counter

assign irq_set = {ee_read_done_i, uart_stat_i.rx_event};
assign irq_clr = (wr_rdy_q && wr_addr == REG_IRQ_STATUS) ? axil_req_i.wdata[1:0] : 2'b00;

always_ff @(posedge clk_i) begin
	if (reset_i) begin
		tx_start_q <= 1'b0;
		rx_ack_q <= 1'b0;
		cfg_wr_en_q <= 1'b0;
		irq_en_q <= '0;
		irq_stat_q <= '0;
		ee_count_q <= '0;
	end else begin
		// Data written while busy is dropped
		tx_start_q <= wr_rdy_q && (wr_addr == REG_UART_DATA) && !uart_stat_i.tx_busy;
		rx_ack_q <= rd_rdy_q && (rd_addr == REG_UART_DATA);
		cfg_wr_en_q <= wr_rdy_q && wr_cfg;
		if (wr_rdy_q && wr_addr == REG_IRQ_ENABLE)
			irq_en_q <= axil_req_i.wdata[1:0];
		// New events win over a clear in the same cycle
		irq_stat_q <= (irq_stat_q & ~irq_clr) | irq_set;
		ee_count_q <= ee_count_q + {7'b0, ee_read_done_i};
	end
end

assign irq_o = |(irq_stat_q & irq_en_q);

assign uart_ctl_o = '{tx_start: tx_start_q, tx_byte: tx_byte_q, rx_ack: rx_ack_q};
assign cfg_wr_o = '{wr_en: cfg_wr_en_q, index: cfg_index_q, word: cfg_word_q};
assign axil_rsp_o = '{
	awready: wr_rdy_q,
	wready:  wr_rdy_q,
	bresp:   bresp_q,
	bvalid:  bvalid_q,
	arready: rd_rdy_q,
	rdata:   rdata_q,
	rresp:   rresp_q,
	rvalid:  rvalid_q
};

//////////////////////////////
// Checks

a_bvalid_hold: assert property (@(posedge clk_i) disable iff (reset_i)
	axil_rsp_o.bvalid && !axil_req_i.bready |=> axil_rsp_o.bvalid);

a_rvalid_hold: assert property (@(posedge clk_i) disable iff (reset_i)
	axil_rsp_o.rvalid && !axil_req_i.rready |=> axil_rsp_o.rvalid);

// Transmitter must be idle whenever a start is issued
a_tx_start_idle: assert property (@(posedge clk_i) disable iff (reset_i)
	!(uart_ctl_o.tx_start && uart_stat_i.tx_busy));

endmodule

/* uart_port.sv */
`timescale 1ns/1ps

module uart_port import card_ctrl_pkg::*; (
	input  logic       clk_i,
	input  logic       reset_i,
	input  uart_ctl_s  uart_ctl_i,
	input  logic       uart_rx_i,
	output uart_stat_s uart_stat_o,
	output logic       uart_tx_o
);

uart_state_e tx_state_q;
logic [UART_CNT_W-1:0] tx_cnt_q;
logic [2:0] tx_idx_q;
logic [7:0] tx_shift_q;
logic tx_q;

uart_state_e rx_state_q;
logic [UART_CNT_W-1:0] rx_cnt_q;
logic [2:0] rx_idx_q;
logic [7:0] rx_shift_q;
logic [1:0] rx_sync_q;
logic rx_prev_q;
logic rx_s;
logic rx_valid_q;
logic rx_overrun_q;
logic [7:0] rx_byte_q;
logic rx_event_q;

//////////////////////////////
// Transmitter

always_ff @(posedge clk_i) begin
	if (reset_i) begin
		tx_state_q <= UART_IDLE;
		tx_q <= 1'b1;
		tx_cnt_q <= '0;
		tx_idx_q <= '0;
	end else begin
		tx_cnt_q <= tx_cnt_q + 1'b1;
		case (tx_state_q)
		UART_IDLE: begin
			tx_q <= 1'b1;
			tx_cnt_q <= '0;
			if (uart_ctl_i.tx_start) begin
				tx_shift_q <= uart_ctl_i.tx_byte;
				tx_q <= 1'b0;
				tx_state_q <= UART_START;
			end
		end
		UART_START: if (tx_cnt_q == UART_CNT_W'(UART_DIV-1)) begin
			// LSB first
			tx_q <= tx_shift_q[0];
			tx_shift_q <= tx_shift_q >> 1;
			tx_idx_q <= '0;
			tx_state_q <= UART_BITS;
		end
		UART_BITS: if (tx_cnt_q == UART_CNT_W'(UART_DIV-1)) begin
			tx_idx_q <= tx_idx_q + 1'b1;
			if (tx_idx_q == 3'd7) begin
				tx_q <= 1'b1;
				tx_state_q <= UART_STOP;
			end else begin
				tx_q <= tx_shift_q[0];
				tx_shift_q <= tx_shift_q >> 1;
			end
		end
		UART_STOP: if (tx_cnt_q == UART_CNT_W'(UART_DIV-1))
			tx_state_q <= UART_IDLE;
		endcase
	end
end

assign uart_tx_o = tx_q;

//////////////////////////////
// Receiver

assign rx_s = rx_sync_q[1];

always_ff @(posedge clk_i) begin
	if (reset_i) begin
		rx_sync_q <= 2'b11;
		rx_prev_q <= 1'b1;
		rx_state_q <= UART_IDLE;
		rx_cnt_q <= '0;
		rx_idx_q <= '0;
		rx_valid_q <= 1'b0;
		rx_overrun_q <= 1'b0;
		rx_byte_q <= '0;
		rx_event_q <= 1'b0;
	end else begin
		rx_sync_q <= {rx_sync_q[0], uart_rx_i};
		rx_prev_q <= rx_s;
		rx_event_q <= 1'b0;
		rx_cnt_q <= rx_cnt_q + 1'b1;
		if (uart_ctl_i.rx_ack) begin
			rx_valid_q <= 1'b0;
			rx_overrun_q <= 1'b0;
		end
		case (rx_state_q)
		UART_IDLE: begin
			rx_cnt_q <= '0;
			if (rx_prev_q && !rx_s)
				rx_state_q <= UART_START;
		end
		// Half a bit in, line must still be low
		UART_START: if (rx_cnt_q == UART_CNT_W'(UART_DIV/2-1)) begin
			rx_cnt_q <= '0;
			rx_idx_q <= '0;
			rx_state_q <= rx_s ? UART_IDLE : UART_BITS;
		end
		UART_BITS: if (rx_cnt_q == UART_CNT_W'(UART_DIV-1)) begin
			rx_shift_q <= {rx_s, rx_shift_q[7:1]};
			rx_idx_q <= rx_idx_q + 1'b1;
			if (rx_idx_q == 3'd7)
				rx_state_q <= UART_STOP;
		end
		UART_STOP: if (rx_cnt_q == UART_CNT_W'(UART_DIV-1)) begin
			rx_state_q <= UART_IDLE;
			// framing error drops the byte
			if (rx_s) begin
				rx_byte_q <= rx_shift_q;
				rx_valid_q <= 1'b1;
				rx_overrun_q <= rx_valid_q && !uart_ctl_i.rx_ack;
				rx_event_q <= 1'b1;
			end
		end
		endcase
	end
end

assign uart_stat_o = '{
	tx_busy:    (tx_state_q != UART_IDLE),
	rx_valid:   rx_valid_q,
	rx_overrun: rx_overrun_q,
	rx_byte:    rx_byte_q,
	rx_event:   rx_event_q
};

a_tx_idle_high: assert property (@(posedge clk_i) disable iff (reset_i)
	tx_state_q == UART_IDLE |-> uart_tx_o);

endmodule
